//--- Makefile
# Verilator build and run for the vector program core
VERILATOR ?= verilator
TOP       ?= gvp_tb
FLIST     ?= gvp_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- gvp_core.f
+incdir+include
src/gvp_pkg.sv
src/gvp_vec_if.sv
src/gvp_timebase.sv
src/gvp_program_mem.sv
src/gvp_sequencer.sv
src/gvp_vector_accum.sv
src/gvp_core.sv
testbench/gvp_tb.sv

//--- include/gvp_defines.svh
`ifndef GVP_DEFINES_SVH
`define GVP_DEFINES_SVH

////////////////////
// program memory sizing
`define GVP_NUM_VECTORS_N2 4            // pc index width
`define GVP_NUM_VECTORS    16           // records in program memory

////////////////////
// data paths
`define GVP_WORD_W         32           // record word / position width
`define GVP_TIME_W         48           // elapsed cycle counter

////////////////////
// store trigger codes on store_data
`define GVP_STORE_NONE     2'd0
`define GVP_STORE_DATA     2'd1         // data point reached
`define GVP_STORE_HEADER   2'd2         // vector header loaded

`endif

//--- src/gvp_core.sv
`timescale 1ns/1ps
`include "gvp_defines.svh"

module gvp_core
(
    input  logic                          a_clk,
    input  logic                          reset_flg,
    input  logic                          program_hold,  // high keeps program at start
    input  logic                          pause,
    input  logic                          setvec,
    input  logic [511:0]                  vp_set,        // full record set word
    input  logic [15:0]                   reset_options, // options when idle
    output logic signed [`GVP_WORD_W-1:0] pos_x,
    output logic signed [`GVP_WORD_W-1:0] pos_y,
    output logic signed [`GVP_WORD_W-1:0] pos_z,
    output logic signed [`GVP_WORD_W-1:0] pos_u,
    output logic [`GVP_WORD_W-1:0]        options,
    output logic [1:0]                    store_data,
    output logic                          finished,
    output logic                          hold,
    output logic [`GVP_WORD_W-1:0]        index,
    output logic [`GVP_WORD_W-1:0]        section_count,
    output logic [`GVP_TIME_W-1:0]        gvp_time
);

    logic                   step_en;
    logic                   deci_load;
    logic [`GVP_WORD_W-1:0] deci_val;
    logic                   add_en;

    gvp_vec_if vec_if ();                       // mem to seq and accum

    ////////////////////
    // blocks
    gvp_timebase u_timebase (
        .a_clk(a_clk), .reset_flg(reset_flg), .program_hold(program_hold),
        .deci_load(deci_load), .deci_val(deci_val),
        .step_en(step_en), .gvp_time(gvp_time)
    );

    gvp_program_mem u_program_mem (
        .a_clk(a_clk), .reset_flg(reset_flg), .setvec(setvec),
        .vp_set(vp_set), .vec(vec_if.mem)
    );

    gvp_sequencer u_sequencer (
        .a_clk(a_clk), .reset_flg(reset_flg), .program_hold(program_hold),
        .pause(pause), .step_en(step_en), .reset_options(reset_options),
        .vec(vec_if.seq), .add_en(add_en), .deci_load(deci_load), .deci_val(deci_val),
        .store_data(store_data), .options(options), .finished(finished), .hold(hold),
        .index(index), .section_count(section_count)
    );

    gvp_vector_accum u_vector_accum (
        .a_clk(a_clk), .reset_flg(reset_flg), .program_hold(program_hold),
        .add_en(add_en), .vec(vec_if.accum),
        .pos_x(pos_x), .pos_y(pos_y), .pos_z(pos_z), .pos_u(pos_u)
    );

endmodule

//--- src/gvp_pkg.sv
`include "gvp_defines.svh"

package gvp_pkg;

    // one vector record as the host sends it
    // word 0 lands in the low 32 bits, so members run from word 15 down
    typedef struct packed
    {
        logic        [`GVP_WORD_W-1:0]      deci;     // word 15
        logic [4:0]  [`GVP_WORD_W-1:0]      reserved; // words 14..10
        logic signed [`GVP_WORD_W-1:0]      du;       // word 9
        logic signed [`GVP_WORD_W-1:0]      dz;
        logic signed [`GVP_WORD_W-1:0]      dy;
        logic signed [`GVP_WORD_W-1:0]      dx;       // word 6
        logic signed [`GVP_WORD_W-1:0]      next;     // relative loop jump
        logic        [`GVP_WORD_W-1:0]      nrep;     // loop repeats
        logic        [`GVP_WORD_W-1:0]      options;
        logic        [`GVP_WORD_W-1:0]      iin;      // steps between points
        logic        [`GVP_WORD_W-1:0]      n;        // points, 0 ends program
        logic        [`GVP_WORD_W-1:0]      addr;     // word 0, target slot
    } gvp_vec_rec_t;

    // same 512 bit set word, seen as fields or as raw words
    typedef union packed
    {
        gvp_vec_rec_t                       rec;
        logic [15:0] [`GVP_WORD_W-1:0]      words;
    } gvp_set_u;

endpackage

//--- src/gvp_program_mem.sv
`timescale 1ns/1ps
`include "gvp_defines.svh"

module gvp_program_mem
    import gvp_pkg::*;
(
    input  logic     a_clk,
    input  logic     reset_flg,
    input  logic     setvec,                    // one cycle host write strobe
    input  gvp_set_u vp_set,
    gvp_vec_if.mem   vec
);

    localparam int AW = `GVP_NUM_VECTORS_N2;

    ////////////////////
    // record storage, one array per field
    logic        [`GVP_WORD_W-1:0] mem_n        [`GVP_NUM_VECTORS];
    logic        [`GVP_WORD_W-1:0] mem_iin      [`GVP_NUM_VECTORS];
    logic        [`GVP_WORD_W-1:0] mem_options  [`GVP_NUM_VECTORS];
    logic        [`GVP_WORD_W-1:0] mem_nrep     [`GVP_NUM_VECTORS];
    logic signed [`GVP_WORD_W-1:0] mem_next     [`GVP_NUM_VECTORS];
    logic        [`GVP_WORD_W-1:0] mem_deci     [`GVP_NUM_VECTORS];
    logic signed [`GVP_WORD_W-1:0] mem_dx       [`GVP_NUM_VECTORS];
    logic signed [`GVP_WORD_W-1:0] mem_dy       [`GVP_NUM_VECTORS];
    logic signed [`GVP_WORD_W-1:0] mem_dz       [`GVP_NUM_VECTORS];
    logic signed [`GVP_WORD_W-1:0] mem_du       [`GVP_NUM_VECTORS];
    logic        [`GVP_WORD_W-1:0] mem_loop_cnt [`GVP_NUM_VECTORS];

    logic [AW-1:0] wr_addr;
    gvp_vec_rec_t  rec;

    assign wr_addr = vp_set.words[0][AW-1:0];   // slot modulo depth
    assign rec     = vp_set.rec;

    always_ff @(posedge a_clk)
    begin
        if (vec.loop_wr)
            mem_loop_cnt[vec.loop_wr_addr] <= vec.loop_wr_val;
        if (setvec)
        begin
            mem_n[wr_addr]        <= rec.n;
            mem_iin[wr_addr]      <= rec.iin;
            mem_options[wr_addr]  <= rec.options;
            mem_nrep[wr_addr]     <= rec.nrep;
            mem_next[wr_addr]     <= rec.next;
            mem_deci[wr_addr]     <= rec.deci;
            mem_dx[wr_addr]       <= rec.dx;
            mem_dy[wr_addr]       <= rec.dy;
            mem_dz[wr_addr]       <= rec.dz;
            mem_du[wr_addr]       <= rec.du;
            mem_loop_cnt[wr_addr] <= rec.nrep;  // fresh loop count
        end
    end

    ////////////////////
    // combinational read at pc
    assign vec.n        = mem_n[vec.rd_addr];
    assign vec.iin      = mem_iin[vec.rd_addr];
    assign vec.options  = mem_options[vec.rd_addr];
    assign vec.nrep     = mem_nrep[vec.rd_addr];
    assign vec.next     = mem_next[vec.rd_addr];
    assign vec.deci     = mem_deci[vec.rd_addr];
    assign vec.dx       = mem_dx[vec.rd_addr];
    assign vec.dy       = mem_dy[vec.rd_addr];
    assign vec.dz       = mem_dz[vec.rd_addr];
    assign vec.du       = mem_du[vec.rd_addr];
    assign vec.loop_cnt = mem_loop_cnt[vec.rd_addr];

    // host must not rewrite the slot whose loop count the sequencer updates
    a_no_wr_clash: assert property (@(posedge a_clk) disable iff (reset_flg)
        (setvec && vec.loop_wr) |-> (wr_addr != vec.loop_wr_addr));
    a_rsv_zero: assert property (@(posedge a_clk) disable iff (reset_flg)
        setvec |-> (vp_set.words[14:10] == '0));

endmodule

//--- src/gvp_sequencer.sv
`timescale 1ns/1ps
`include "gvp_defines.svh"

module gvp_sequencer
(
    input  logic                   a_clk,
    input  logic                   reset_flg,
    input  logic                   program_hold,
    input  logic                   pause,
    input  logic                   step_en,
    input  logic [15:0]            reset_options,
    gvp_vec_if.seq                 vec,
    output logic                   add_en,
    output logic                   deci_load,
    output logic [`GVP_WORD_W-1:0] deci_val,
    output logic [1:0]             store_data,
    output logic [`GVP_WORD_W-1:0] options,
    output logic                   finished,
    output logic                   hold,
    output logic [`GVP_WORD_W-1:0] index,
    output logic [`GVP_WORD_W-1:0] section_count
);

    localparam int W  = `GVP_WORD_W;
    localparam int AW = `GVP_NUM_VECTORS_N2;

    logic [AW-1:0]       pc;                    // program counter
    logic [W-1:0]        i_cnt;                 // points left
    logic [W-1:0]        ii_cnt;                // intermediate steps left
    logic                load_next;
    logic                active;
    logic                stall;
    logic                sec_end;
    logic                jump;                  // loop back taken
    logic signed [W:0]   pc_step;
    logic signed [W:0]   pc_target;             // wide so overflow is visible

    ////////////////////
    // step decode
    assign active    = step_en && !program_hold && !finished;
    assign stall     = !load_next && (ii_cnt == '0) && pause;
    assign sec_end   = active && !load_next && (ii_cnt == '0) && !pause && (i_cnt == '0);
    assign jump      = (vec.loop_cnt != '0);
    assign pc_step   = jump ? {vec.next[W-1], vec.next} : (W+1)'(1);
    assign pc_target = $signed({{(W+1-AW){1'b0}}, pc}) + pc_step;

    assign add_en    = active && !load_next && !stall; // every non load, non stall step
    assign deci_load = active && load_next;
    assign deci_val  = (vec.n == '0) ? '0 : vec.deci;  // end record goes back to full rate

    assign vec.rd_addr      = pc;
    assign vec.loop_wr      = sec_end;
    assign vec.loop_wr_addr = pc;
    assign vec.loop_wr_val  = jump ? vec.loop_cnt - 1'b1 : vec.nrep; // rearm when done

    assign index = i_cnt;

    always_ff @(posedge a_clk)
    begin
        if (reset_flg || program_hold)
        begin
            pc            <= '0;
            i_cnt         <= '0;
            ii_cnt        <= '0;
            load_next     <= 1'b1;              // start with header of record 0
            finished      <= 1'b0;
            hold          <= 1'b0;
            store_data    <= `GVP_STORE_NONE;
            options       <= {{(W-16){1'b0}}, reset_options};
            section_count <= '0;
        end
        else
        begin
            store_data <= `GVP_STORE_NONE;      // triggers are single cycle
            if (active)
            begin
                hold <= 1'b0;
                if (load_next)
                begin
                    store_data <= `GVP_STORE_HEADER;
                    load_next  <= 1'b0;
                    i_cnt      <= vec.n;
                    ii_cnt     <= vec.iin;
                    if (vec.n == '0)
                    begin
                        finished <= 1'b1;       // end of program
                        options  <= {{(W-16){1'b0}}, reset_options};
                    end
                    else
                        options <= vec.options;
                end
                else if (ii_cnt != '0)
                    ii_cnt <= ii_cnt - 1'b1;    // intermediate step
                else if (pause)
                    hold <= 1'b1;               // wait at data point
                else if (i_cnt != '0)
                begin
                    store_data <= `GVP_STORE_DATA;
                    ii_cnt     <= vec.iin;
                    i_cnt      <= i_cnt - 1'b1;
                end
                else
                begin
                    section_count <= section_count + 1'b1;
                    pc            <= pc_target[AW-1:0];
                    load_next     <= 1'b1;
                end
            end
        end
    end

    a_store_code: assert property (@(posedge a_clk) disable iff (reset_flg)
        store_data != 2'd3);
    // jumps and fall through must land on a real record
    a_pc_range: assert property (@(posedge a_clk) disable iff (reset_flg)
        sec_end |-> (pc_target >= 0 && pc_target < `GVP_NUM_VECTORS));

endmodule

//--- src/gvp_timebase.sv
`timescale 1ns/1ps
`include "gvp_defines.svh"

module gvp_timebase
(
    input  logic                   a_clk,
    input  logic                   reset_flg,
    input  logic                   program_hold,
    input  logic                   deci_load,   // load step of a new record
    input  logic [`GVP_WORD_W-1:0] deci_val,
    output logic                   step_en,     // clock enable for the sequencer
    output logic [`GVP_TIME_W-1:0] gvp_time
);

    logic [`GVP_WORD_W-1:0] deci_reg;           // decimation in force
    logic [`GVP_WORD_W-1:0] deci_cnt;           // cycles until next step

    // held core runs every cycle so it can settle into its start state
    assign step_en = program_hold || (deci_cnt == '0);

    always_ff @(posedge a_clk)
    begin
        if (reset_flg || program_hold)
        begin
            deci_reg <= '0;
            deci_cnt <= '0;                     // first step right after release
            gvp_time <= '0;
        end
        else
        begin
            gvp_time <= gvp_time + 1'b1;
            if (deci_load)
                deci_reg <= deci_val;
            if (deci_cnt == '0)
                deci_cnt <= deci_load ? deci_val : deci_reg; // new deci counts from load step
            else
                deci_cnt <= deci_cnt - 1'b1;
        end
    end

    // hold forces a step every cycle
    a_step_held: assert property (@(posedge a_clk) disable iff (reset_flg)
        program_hold |-> step_en);

endmodule

//--- src/gvp_vec_if.sv
`timescale 1ns/1ps
`include "gvp_defines.svh"

interface gvp_vec_if;

    logic        [`GVP_NUM_VECTORS_N2-1:0] rd_addr;      // current pc
    logic        [`GVP_WORD_W-1:0]         n;
    logic        [`GVP_WORD_W-1:0]         iin;
    logic        [`GVP_WORD_W-1:0]         options;
    logic        [`GVP_WORD_W-1:0]         nrep;
    logic signed [`GVP_WORD_W-1:0]         next;
    logic        [`GVP_WORD_W-1:0]         deci;
    logic signed [`GVP_WORD_W-1:0]         dx;
    logic signed [`GVP_WORD_W-1:0]         dy;
    logic signed [`GVP_WORD_W-1:0]         dz;
    logic signed [`GVP_WORD_W-1:0]         du;
    logic        [`GVP_WORD_W-1:0]         loop_cnt;     // live repeat counter
    logic                                  loop_wr;      // section end write-back
    logic        [`GVP_WORD_W-1:0]         loop_wr_val;
    logic        [`GVP_NUM_VECTORS_N2-1:0] loop_wr_addr;

    modport mem
    (
        input  rd_addr, loop_wr, loop_wr_val, loop_wr_addr,
        output n, iin, options, nrep, next, deci, dx, dy, dz, du, loop_cnt
    );

    modport seq
    (
        output rd_addr, loop_wr, loop_wr_val, loop_wr_addr,
        input  n, iin, options, nrep, next, deci, dx, dy, dz, du, loop_cnt
    );

    modport accum (input dx, dy, dz, du); // increments only

endinterface

//--- src/gvp_vector_accum.sv
`timescale 1ns/1ps
`include "gvp_defines.svh"

module gvp_vector_accum
(
    input  logic                          a_clk,
    input  logic                          reset_flg,
    input  logic                          program_hold,
    input  logic                          add_en,
    gvp_vec_if.accum                      vec,
    output logic signed [`GVP_WORD_W-1:0] pos_x,
    output logic signed [`GVP_WORD_W-1:0] pos_y,
    output logic signed [`GVP_WORD_W-1:0] pos_z,
    output logic signed [`GVP_WORD_W-1:0] pos_u
);

    logic hold_d;                               // program_hold last cycle
    logic hold_rise;

    assign hold_rise = program_hold && !hold_d; // new run is being armed

    always_ff @(posedge a_clk)
    begin
        if (reset_flg)
            hold_d <= 1'b0;
        else
            hold_d <= program_hold;
    end

    always_ff @(posedge a_clk)
    begin
        if (reset_flg || hold_rise)
        begin
            pos_x <= '0;
            pos_y <= '0;
            pos_z <= '0;
            pos_u <= '0;
        end
        else if (add_en)
        begin
            pos_x <= pos_x + vec.dx;            // wraps like the dac word
            pos_y <= pos_y + vec.dy;
            pos_z <= pos_z + vec.dz;
            pos_u <= pos_u + vec.du;
        end
    end

endmodule

//--- testbench/gvp_cases.txt
# case <deci> <pause_len>            pause_len 0 runs the case without a pause
# rec  <addr> <n> <iin> <options hex> <nrep> <next> <dx> <dy> <dz> <du>
# exp  <x> <y> <z> <u> <header stores> <data stores> <sections>

# single vector
case 0 0
rec 0 3 1 11 0 0 5 -2 100 -7
rec 1 0 0 0 0 0 0 0 0 0
exp 40 -16 800 -56 2 3 1

# two records looped three times by a jump of -1
case 0 5
rec 0 1 0 21 0 0 1 0 -4 0
rec 1 2 1 22 2 -1 10 -3 0 1
rec 2 0 0 0 0 0 0 0 0 0
exp 186 -54 -24 18 7 9 6

# decimated run over two records
case 3 12
rec 0 2 2 31 0 0 7 1 -1 2
rec 1 1 0 32 0 0 -3 4 0 0
rec 2 0 0 0 0 0 0 0 0 0
exp 57 17 -9 18 3 3 2

# record repeating itself, then a short one
case 1 7
rec 0 1 3 41 2 0 -100 250 3 -1
rec 1 2 0 42 0 0 1 1 1 1
rec 2 0 0 0 0 0 0 0 0 0
exp -2397 6003 75 -21 5 5 4

# wrapping x, end record written through address 17
case 2 9
rec 0 4 0 51 1 0 1073741824 -1 123456 -5
rec 17 0 0 0 0 0 0 0 0 0
exp -2147483648 -10 1234560 -50 3 8 2

//--- testbench/gvp_tb.sv
`timescale 1ns/1ps
`include "gvp_defines.svh"

module gvp_tb;

    localparam int          RUN_LIMIT  = 5000;  // cycles for a whole program
    localparam int          HOLD_LIMIT = 200;   // cycles for a pause to stall
    localparam logic [15:0] RST_OPT    = 16'h00a5;

    logic               a_clk;
    logic               reset_flg;
    logic               program_hold;
    logic               pause;
    logic               setvec;
    logic [511:0]       vp_set;
    logic [15:0]        reset_options;
    logic signed [31:0] pos_x;
    logic signed [31:0] pos_y;
    logic signed [31:0] pos_z;
    logic signed [31:0] pos_u;
    logic [31:0]        options;
    logic [1:0]         store_data;
    logic               finished;
    logic               hold;
    logic [31:0]        index;
    logic [31:0]        section_count;
    logic [47:0]        gvp_time;

    ////////////////////
    // current case, fields kept per record slot for the pc walk
    logic [31:0]        r_n    [16];
    logic [31:0]        r_opt  [16];
    logic [31:0]        r_nrep [16];
    logic signed [31:0] r_next [16];
    logic [511:0]       set_q  [$];             // set words in file order
    int c_deci;
    int c_pause_len;
    int exp_x, exp_y, exp_z, exp_u;
    int exp_hdr, exp_dat, exp_sec;
    int f_addr, f_n, f_iin, f_opt, f_nrep, f_next, f_dx, f_dy, f_dz, f_du;
    int case_no;
    int errors;
    int timeouts;
    bit timed_out;
    logic [31:0] lcg_state;

    gvp_core dut0 (
        .a_clk(a_clk), .reset_flg(reset_flg), .program_hold(program_hold),
        .pause(pause), .setvec(setvec), .vp_set(vp_set), .reset_options(reset_options),
        .pos_x(pos_x), .pos_y(pos_y), .pos_z(pos_z), .pos_u(pos_u),
        .options(options), .store_data(store_data), .finished(finished), .hold(hold),
        .index(index), .section_count(section_count), .gvp_time(gvp_time)
    );

    initial
    begin
        a_clk = 1'b0;
        forever #2 a_clk = ~a_clk;              // 4 ns period
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    ////////////////////
    // result compares
    task automatic check_position(input string name, input logic signed [31:0] got,
                                  input logic signed [31:0] want);
        if (got !== want)
        begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic verify_store_code(input string name, input logic [1:0] got,
                                     input logic [1:0] want);
        if (got !== want)
        begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        if (got !== want)
        begin
            $display("[ERROR] %0t %s got 0x%0h expected 0x%0h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic write_records();
        foreach (set_q[k])
        begin
            @(negedge a_clk);
            setvec = 1'b1;
            vp_set = set_q[k];
        end
        @(negedge a_clk);
        setvec = 1'b0;
    endtask

    task automatic rearm_hold();
        @(negedge a_clk);
        program_hold = 1'b1;
        pause        = 1'b0;
        @(negedge a_clk);
        check_position("pos_x after hold", pos_x, 32'sd0); // cleared on hold rise
        if (finished)
        begin
            $display("finished stayed high after program_hold rose in case %0d", case_no);
            errors++;
        end
    endtask

    task automatic run_program(input bit with_pause);
        int                 cyc;
        int                 hdr_cyc;
        int                 hdr_cnt;
        int                 dat_cnt;
        int                 pause_at;
        int                 pstate;             // 0 idle 1 waiting 2 stalled 3 released
        int                 pcount;
        logic [3:0]         mpc;                // expected pc
        logic [31:0]        lcnt [16];
        logic signed [31:0] prev_x;
        logic signed [31:0] fx, fy, fz, fu;     // frozen during pause
        cyc      = 0;
        hdr_cyc  = 0;
        hdr_cnt  = 0;
        dat_cnt  = 0;
        pstate   = 0;
        pcount   = 0;
        mpc      = 4'd0;
        pause_at = 1 + int'(lcg_next() % 32'd6);
        for (int k = 0; k < 16; k++)
            lcnt[4'(k)] = r_nrep[4'(k)];
        prev_x       = pos_x;
        program_hold = 1'b0;                    // release, first step is record 0 header
        while (!finished && !timed_out && cyc < RUN_LIMIT)
        begin
            @(negedge a_clk);
            cyc++;
            if (store_data == `GVP_STORE_HEADER)
            begin
                hdr_cnt++;
                if (hdr_cnt == 1)
                    hdr_cyc = cyc;
                compare_word("options at header", options,
                             (r_n[mpc] == '0) ? {16'h0000, RST_OPT} : r_opt[mpc]);
                compare_word("index at header", index, r_n[mpc]); // points of the new record
                if (r_n[mpc] != '0)             // walk on as the loop rule says
                begin
                    if (lcnt[mpc] != '0)
                    begin
                        lcnt[mpc] = lcnt[mpc] - 32'd1;
                        mpc       = mpc + r_next[mpc][3:0];
                    end
                    else
                    begin
                        lcnt[mpc] = r_nrep[mpc];
                        mpc       = mpc + 4'd1;
                    end
                end
            end
            if (store_data == `GVP_STORE_DATA)
                dat_cnt++;
            if (!with_pause && pos_x != prev_x && (cyc - hdr_cyc) % (c_deci + 1) != 0)
            begin
                $display("pos_x moved %0d cycles after the first header, off the deci %0d grid",
                         cyc - hdr_cyc, c_deci);
                errors++;
            end
            prev_x = pos_x;
            case (pstate)
                0:
                    if (with_pause && cyc == pause_at)
                    begin
                        pause  = 1'b1;
                        pstate = 1;
                    end
                1:
                begin
                    pcount++;
                    if (hold)
                    begin
                        fx     = pos_x;
                        fy     = pos_y;
                        fz     = pos_z;
                        fu     = pos_u;
                        pcount = 0;
                        pstate = 2;
                    end
                    else if (pcount > HOLD_LIMIT)
                    begin
                        $display("timeout waiting for hold after pause in case %0d", case_no);
                        timeouts++;
                        timed_out = 1'b1;
                    end
                end
                2:
                begin
                    check_position("pos_x in pause", pos_x, fx);
                    check_position("pos_y in pause", pos_y, fy);
                    check_position("pos_z in pause", pos_z, fz);
                    check_position("pos_u in pause", pos_u, fu);
                    if (!hold)
                    begin
                        $display("hold dropped while pause was high in case %0d", case_no);
                        errors++;
                    end
                    pcount++;
                    if (pcount >= c_pause_len)
                    begin
                        pause  = 1'b0;
                        pstate = 3;
                    end
                end
                default:
                    ;
            endcase
        end
        if (!timed_out && !finished)
        begin
            $display("timeout waiting for finished in case %0d", case_no);
            timeouts++;
            timed_out = 1'b1;
        end
        else if (!timed_out)
        begin
            if (with_pause && pstate != 3)
            begin
                $display("pause in case %0d never stalled the program", case_no);
                errors++;
            end
            check_position("pos_x", pos_x, exp_x);
            check_position("pos_y", pos_y, exp_y);
            check_position("pos_z", pos_z, exp_z);
            check_position("pos_u", pos_u, exp_u);
            compare_word("header stores", hdr_cnt, exp_hdr);
            compare_word("data stores", dat_cnt, exp_dat);
            compare_word("section_count", section_count, exp_sec);
            compare_word("options at finish", options, {16'h0000, RST_OPT});
            compare_word("gvp_time", gvp_time[31:0], cyc); // cycles since release
            @(negedge a_clk);
            verify_store_code("store_data after finish", store_data, `GVP_STORE_NONE);
        end
    endtask

    initial
    begin
        int    fd;
        int    code;
        string line;
        string kw;
        reset_flg     = 1'b1;
        program_hold  = 1'b1;
        pause         = 1'b0;
        setvec        = 1'b0;
        vp_set        = '0;
        reset_options = RST_OPT;
        errors        = 0;
        timeouts      = 0;
        timed_out     = 1'b0;
        case_no       = 0;
        lcg_state     = 32'h4641;
        repeat (16) @(posedge a_clk);
        @(negedge a_clk);
        reset_flg = 1'b0;
        @(negedge a_clk);

        ////////////////////
        // state straight out of reset
        verify_store_code("store_data", store_data, `GVP_STORE_NONE);
        check_position("pos_x", pos_x, 32'sd0);
        check_position("pos_y", pos_y, 32'sd0);
        check_position("pos_z", pos_z, 32'sd0);
        check_position("pos_u", pos_u, 32'sd0);
        compare_word("options", options, {16'h0000, RST_OPT});
        if (finished || hold)
        begin
            $display("finished or hold is high after reset");
            errors++;
        end

        fd = $fopen("testbench/gvp_cases.txt", "r");
        if (fd == 0)
        begin
            $display("could not open testbench/gvp_cases.txt");
            errors++;
        end
        else
        begin
            while (!timed_out && $fgets(line, fd) != 0)
            begin
                code = $sscanf(line, "%s", kw);
                if (code < 1 || kw.substr(0, 0) == "#")
                    continue;                   // blank or comment
                if (kw == "case")
                begin
                    code = $sscanf(line, "case %d %d", c_deci, c_pause_len);
                    set_q.delete();
                    for (int k = 0; k < 16; k++)
                    begin
                        r_n[4'(k)]    = '0;
                        r_opt[4'(k)]  = '0;
                        r_nrep[4'(k)] = '0;
                        r_next[4'(k)] = '0;
                    end
                end
                else if (kw == "rec")
                begin
                    code = $sscanf(line, "rec %d %d %d %h %d %d %d %d %d %d", f_addr, f_n,
                                   f_iin, f_opt, f_nrep, f_next, f_dx, f_dy, f_dz, f_du);
                    r_n[4'(f_addr)]    = f_n;   // slot is address modulo 16
                    r_opt[4'(f_addr)]  = f_opt;
                    r_nrep[4'(f_addr)] = f_nrep;
                    r_next[4'(f_addr)] = f_next;
                    set_q.push_back({c_deci, 160'd0, f_du, f_dz, f_dy, f_dx, f_next,
                                     f_nrep, f_opt, f_iin, f_n, f_addr});
                end
                else if (kw == "exp")
                begin
                    code = $sscanf(line, "exp %d %d %d %d %d %d %d", exp_x, exp_y, exp_z,
                                   exp_u, exp_hdr, exp_dat, exp_sec);
                    case_no++;
                    write_records();
                    run_program(1'b0);
                    rearm_hold();
                    if (!timed_out && c_pause_len > 0)
                    begin
                        write_records();        // same program again, now with a pause
                        run_program(1'b1);
                        rearm_hold();
                    end
                end
                else
                begin
                    $display("unknown line in cases file: %s", line);
                    errors++;
                end
            end
            $fclose(fd);
        end

        $display("cases %0d  errors %0d  timeouts %0d", case_no, errors, timeouts);
        if (errors == 0 && timeouts == 0 && case_no > 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule
